// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [3:0]  nibbleT;
    typedef logic [2:0]  cycleT;
    typedef logic [11:0] romAddrT;

    // ====================================================================
    // Main opcodes, upper nibble of the instruction byte
    // ====================================================================
    localparam nibbleT NOP   = 4'h0;
    localparam nibbleT JCN   = 4'h1;
    localparam nibbleT FIM   = 4'h2;
    localparam nibbleT FIN   = 4'h3;
    localparam nibbleT JUN   = 4'h4;
    localparam nibbleT JMS   = 4'h5;
    localparam nibbleT INC   = 4'h6;
    localparam nibbleT ISZ   = 4'h7;
    localparam nibbleT ADD   = 4'h8;
    localparam nibbleT SUB   = 4'h9;
    localparam nibbleT LD    = 4'hA;
    localparam nibbleT XCH   = 4'hB;
    localparam nibbleT BBL   = 4'hC;
    localparam nibbleT LDM   = 4'hD;
    localparam nibbleT GRP_E = 4'hE;    // RAM and I/O group
    localparam nibbleT GRP_F = 4'hF;    // Accumulator and carry group

    // E group subcodes
    localparam nibbleT WRM = 4'h0;
    localparam nibbleT WMP = 4'h1;
    localparam nibbleT WRR = 4'h2;
    localparam nibbleT WPM = 4'h3;
    localparam nibbleT WR0 = 4'h4;      // Status character writes
    localparam nibbleT WR1 = 4'h5;
    localparam nibbleT WR2 = 4'h6;
    localparam nibbleT WR3 = 4'h7;
    localparam nibbleT SBM = 4'h8;
    localparam nibbleT RDM = 4'h9;
    localparam nibbleT RDR = 4'hA;
    localparam nibbleT ADM = 4'hB;
    localparam nibbleT RD0 = 4'hC;      // Status character reads
    localparam nibbleT RD1 = 4'hD;
    localparam nibbleT RD2 = 4'hE;
    localparam nibbleT RD3 = 4'hF;

    // F group subcodes, 0xD to 0xF unused
    localparam nibbleT CLB = 4'h0;
    localparam nibbleT CLC = 4'h1;
    localparam nibbleT IAC = 4'h2;
    localparam nibbleT CMC = 4'h3;
    localparam nibbleT CMA = 4'h4;
    localparam nibbleT RAL = 4'h5;
    localparam nibbleT RAR = 4'h6;
    localparam nibbleT TCC = 4'h7;
    localparam nibbleT DAC = 4'h8;
    localparam nibbleT TCS = 4'h9;
    localparam nibbleT STC = 4'hA;
    localparam nibbleT DAA = 4'hB;
    localparam nibbleT KBP = 4'hC;

    // Execute sub-cycles
    localparam cycleT CYC_X1 = 3'd5;
    localparam cycleT CYC_X2 = 3'd6;
    localparam cycleT CYC_X3 = 3'd7;

    typedef struct packed {
        logic invert;       // Complement the result
        logic zeroEn;
        logic carryEn;
        logic testLowEn;    // Test pin low
    } condFieldsT;

    // Operand nibble, JCN condition or register index and subcode
    typedef union packed {
        condFieldsT cond;
        nibbleT     code;
    } operandU;

    typedef struct packed {
        nibbleT  opr;
        operandU opa;
    } instrT;

endpackage

`default_nettype wire

// ==== hw/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // ALU B-operand source
    typedef logic [1:0] aluSelT;
    localparam aluSelT SEL_REG  = 2'd0;
    localparam aluSelT SEL_IMM  = 2'd1;
    localparam aluSelT SEL_RAM  = 2'd2;
    localparam aluSelT SEL_NONE = 2'd3;

    typedef struct packed {
        logic           enable;
        isaPkg::nibbleT op;
        isaPkg::nibbleT subOp;
        aluSelT         sel;
    } aluCtrlT;

    typedef struct packed {
        logic accWe;
        logic tempWe;
        logic regWe;
        logic regSrcSel;    // Register file takes temp instead of ALU
    } wrCtrlT;

    typedef struct packed {
        logic ramWe;
        logic ramRe;
        logic ioWe;
        logic ioRe;
    } memCtrlT;

    typedef struct packed {
        logic            pcLoad;
        isaPkg::romAddrT pcLoadData;
        logic            stackPush;
        logic            stackPop;
    } pcCtrlT;

    typedef struct packed {
        logic carry;
        logic zero;
    } aluStatusT;

    // ====================================================================
    // Flag update command, applied by the flag unit at each edge
    // ====================================================================
    typedef logic [2:0] carryModeT;
    localparam carryModeT CM_KEEP   = 3'd0;
    localparam carryModeT CM_ALU    = 3'd1;
    localparam carryModeT CM_CLEAR  = 3'd2;
    localparam carryModeT CM_SET    = 3'd3;
    localparam carryModeT CM_INVERT = 3'd4;

    typedef struct packed {
        carryModeT carryMode;
        logic      zeroTake;    // Zero flag from the ALU
    } flagCmdT;

    localparam aluCtrlT ALU_IDLE  = '{enable: 1'b0, op: 4'h0, subOp: 4'h0, sel: SEL_NONE};
    localparam wrCtrlT  WR_IDLE   = '0;
    localparam memCtrlT MEM_IDLE  = '0;
    localparam pcCtrlT  PC_IDLE   = '0;
    localparam flagCmdT FLAG_KEEP = '{carryMode: CM_KEEP, zeroTake: 1'b0};

endpackage

`default_nettype wire

// ==== hw/flagUnit.sv ====
`default_nettype none

module flagUnit (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire ctrlPkg::flagCmdT   flagCmd,
    input  wire ctrlPkg::aluStatusT aluStatus,
    input  wire                     testFlag,
    input  wire isaPkg::operandU    opa,
    output logic                    carryFlag,
    output logic                    zeroFlag,
    output logic                    ccOut
);
    import ctrlPkg::*;

    logic carryNext;
    logic condHit;

    always_comb begin
        case (flagCmd.carryMode)
            CM_KEEP:   carryNext = carryFlag;
            CM_ALU:    carryNext = aluStatus.carry;
            CM_CLEAR:  carryNext = 1'b0;
            CM_SET:    carryNext = 1'b1;
            CM_INVERT: carryNext = ~carryFlag;  // CMC
            default:   carryNext = carryFlag;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carryFlag <= 1'b0;
            zeroFlag  <= 1'b0;
        end else begin
            carryFlag <= carryNext;
            if (flagCmd.zeroTake) begin
                zeroFlag <= aluStatus.zero;
            end
        end
    end

    // JCN condition, combinational so the CPU top sees it in the same cycle
    assign condHit = (opa.cond.testLowEn & ~testFlag)
                   | (opa.cond.carryEn & carryFlag)
                   | (opa.cond.zeroEn & zeroFlag);
    assign ccOut   = condHit ^ opa.cond.invert;

endmodule

`default_nettype wire

// ==== hw/jumpSequencer.sv ====
`default_nettype none

module jumpSequencer (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire isaPkg::nibbleT   opr,
    input  wire isaPkg::cycleT    cycle,
    input  wire                   immFetchActive,
    input  wire isaPkg::romAddrT  immAddr,
    output logic                  needImm,
    output ctrlPkg::pcCtrlT       pcCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic   longJump;       // JUN or JMS at X3
    logic   needImmNext;
    pcCtrlT pcNext;

    assign longJump = (cycle == CYC_X3) && ((opr == JUN) || (opr == JMS));

    always_comb begin
        pcNext      = PC_IDLE;
        needImmNext = longJump && !immFetchActive;  // First word asks for the second
        if (longJump && immFetchActive) begin
            pcNext.pcLoad     = 1'b1;
            pcNext.pcLoadData = immAddr;
            pcNext.stackPush  = (opr == JMS);       // Return address pushed by the top
        end
        pcNext.stackPop = (cycle == CYC_X3) && (opr == BBL);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            needImm <= 1'b0;
            pcCtrl  <= PC_IDLE;
        end else begin
            needImm <= needImmNext;
            pcCtrl  <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/eGroupDecoder.sv ====
`default_nettype none

module eGroupDecoder (
    input  wire isaPkg::nibbleT  opa,
    input  wire isaPkg::cycleT   cycle,
    output ctrlPkg::aluCtrlT     aluCtrl,
    output ctrlPkg::wrCtrlT      wrCtrl,
    output ctrlPkg::memCtrlT     memCtrl,
    output ctrlPkg::flagCmdT     flagCmd
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic   ramRead;    // Instruction reads RAM through the ALU
    nibbleT readOp;

    always_comb begin
        aluCtrl = ALU_IDLE;
        wrCtrl  = WR_IDLE;
        memCtrl = MEM_IDLE;
        flagCmd = FLAG_KEEP;
        ramRead = 1'b0;
        readOp  = LD;

        case (opa)
            WRM, WR0, WR1, WR2, WR3: memCtrl.ramWe = (cycle == CYC_X3);
            WMP, WRR:                memCtrl.ioWe  = (cycle == CYC_X3);
            WPM:                     ;                      // No program RAM here
            SBM: begin
                ramRead = 1'b1;
                readOp  = SUB;
            end
            ADM: begin
                ramRead = 1'b1;
                readOp  = ADD;
            end
            RDM, RD0, RD1, RD2, RD3: ramRead = 1'b1;
            RDR: begin
                memCtrl.ioRe = (cycle == CYC_X3);
                wrCtrl.accWe = (cycle == CYC_X3);
            end
        endcase

        // RAM data goes through the ALU at X2, result lands at X3
        if (ramRead && (cycle == CYC_X2)) begin
            memCtrl.ramRe  = 1'b1;
            aluCtrl.enable = 1'b1;
            aluCtrl.op     = readOp;
            aluCtrl.sel    = SEL_RAM;
        end
        if (ramRead && (cycle == CYC_X3)) begin
            wrCtrl.accWe = 1'b1;
            if (readOp != LD) begin
                flagCmd = '{carryMode: CM_ALU, zeroTake: 1'b1};    // SBM, ADM
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fGroupDecoder.sv ====
`default_nettype none

module fGroupDecoder (
    input  wire isaPkg::nibbleT  opa,
    input  wire isaPkg::cycleT   cycle,
    output ctrlPkg::aluCtrlT     aluCtrl,
    output ctrlPkg::wrCtrlT      wrCtrl,
    output ctrlPkg::flagCmdT     flagCmd
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic known;    // Subcodes CLB to KBP

    assign known = (opa <= KBP);

    always_comb begin
        aluCtrl = ALU_IDLE;
        wrCtrl  = WR_IDLE;
        flagCmd = FLAG_KEEP;

        if (known) begin
            aluCtrl.enable = 1'b1;
            aluCtrl.op     = GRP_F;
            aluCtrl.subOp  = opa;
        end

        if (known && (cycle == CYC_X3)) begin
            wrCtrl.accWe = !(opa inside {CLC, CMC, STC});  // Carry-only subcodes
            case (opa)
                CLB, CLC, TCC, TCS:      flagCmd.carryMode = CM_CLEAR;
                STC:                     flagCmd.carryMode = CM_SET;
                CMC:                     flagCmd.carryMode = CM_INVERT;
                IAC, RAL, RAR, DAC, DAA: flagCmd.carryMode = CM_ALU;
                CMA, KBP:                flagCmd.carryMode = CM_KEEP;
            endcase
            flagCmd.zeroTake = (opa == IAC) || (opa == DAC);
        end
    end

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire isaPkg::instrT   instr,
    input  wire isaPkg::cycleT   cycle,
    output ctrlPkg::aluCtrlT     aluCtrl,
    output ctrlPkg::wrCtrlT      wrCtrl,
    output ctrlPkg::memCtrlT     memCtrl,
    output ctrlPkg::flagCmdT     flagCmd
);
    import isaPkg::*;
    import ctrlPkg::*;

    aluCtrlT eAlu;
    aluCtrlT fAlu;
    aluCtrlT aluNext;
    wrCtrlT  eWr;
    wrCtrlT  fWr;
    wrCtrlT  wrNext;
    memCtrlT eMem;
    memCtrlT memNext;
    flagCmdT eFlag;
    flagCmdT fFlag;
    logic    atX3;

    eGroupDecoder uEGroup (
        .opa     (instr.opa.code),
        .cycle   (cycle),
        .aluCtrl (eAlu),
        .wrCtrl  (eWr),
        .memCtrl (eMem),
        .flagCmd (eFlag)
    );

    fGroupDecoder uFGroup (
        .opa     (instr.opa.code),
        .cycle   (cycle),
        .aluCtrl (fAlu),
        .wrCtrl  (fWr),
        .flagCmd (fFlag)
    );

    assign atX3 = (cycle == CYC_X3);

    // ====================================================================
    // Next-state decode on the main opcode
    // ====================================================================
    always_comb begin
        aluNext = ALU_IDLE;
        wrNext  = WR_IDLE;
        memNext = MEM_IDLE;
        flagCmd = FLAG_KEEP;

        case (instr.opr)
            INC, ADD, SUB, LD: begin
                aluNext.enable = 1'b1;
                aluNext.op     = instr.opr;
                aluNext.sel    = SEL_REG;
                wrNext.regWe   = atX3 && (instr.opr == INC);
                wrNext.accWe   = atX3 && (instr.opr != INC);
                if (atX3) begin
                    flagCmd.carryMode = (instr.opr == LD) ? CM_KEEP : CM_ALU;
                    flagCmd.zeroTake  = 1'b1;
                end
            end
            XCH: begin
                wrNext.accWe     = atX3;
                wrNext.regWe     = atX3;
                wrNext.regSrcSel = atX3;    // Old accumulator via temp
            end
            BBL, LDM: begin
                aluNext.enable   = 1'b1;
                aluNext.op       = instr.opr;
                aluNext.sel      = SEL_IMM;
                wrNext.accWe     = atX3;
                flagCmd.zeroTake = atX3 && (instr.opr == LDM);
            end
            GRP_E: begin
                aluNext = eAlu;
                wrNext  = eWr;
                memNext = eMem;
                flagCmd = eFlag;
            end
            GRP_F: begin
                aluNext = fAlu;
                wrNext  = fWr;
                flagCmd = fFlag;
            end
            NOP, JCN, FIM, FIN, JUN, JMS, ISZ: ;  // Jumps live in jumpSequencer
        endcase

        wrNext.tempWe = (cycle == CYC_X1);      // Temp latches ACC for every opcode
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluCtrl <= ALU_IDLE;
            wrCtrl  <= WR_IDLE;
            memCtrl <= MEM_IDLE;
        end else begin
            aluCtrl <= aluNext;
            wrCtrl  <= wrNext;
            memCtrl <= memNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decoderWithCc.sv ====
`default_nettype none

module decoderWithCc (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire isaPkg::instrT      instr,
    input  wire isaPkg::cycleT      cycle,
    input  wire ctrlPkg::aluStatusT aluStatus,
    input  wire                     testFlag,
    input  wire                     immFetchActive,
    input  wire isaPkg::romAddrT    immAddr,
    output logic                    needImm,
    output ctrlPkg::aluCtrlT        aluCtrl,
    output ctrlPkg::wrCtrlT         wrCtrl,
    output ctrlPkg::memCtrlT        memCtrl,
    output ctrlPkg::pcCtrlT         pcCtrl,
    output logic                    carryFlag,
    output logic                    zeroFlag,
    output logic                    ccOut
);
    import ctrlPkg::*;

    wire flagCmdT flagCmd;    // Decoder to flag unit

    instrDecoder uDecoder (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .cycle   (cycle),
        .aluCtrl (aluCtrl),
        .wrCtrl  (wrCtrl),
        .memCtrl (memCtrl),
        .flagCmd (flagCmd)
    );

    flagUnit uFlags (
        .clk       (clk),
        .rstN      (rstN),
        .flagCmd   (flagCmd),
        .aluStatus (aluStatus),
        .testFlag  (testFlag),
        .opa       (instr.opa),     // Condition view for JCN
        .carryFlag (carryFlag),
        .zeroFlag  (zeroFlag),
        .ccOut     (ccOut)
    );

    jumpSequencer uJump (
        .clk            (clk),
        .rstN           (rstN),
        .opr            (instr.opr),
        .cycle          (cycle),
        .immFetchActive (immFetchActive),
        .immAddr        (immAddr),
        .needImm        (needImm),
        .pcCtrl         (pcCtrl)
    );

endmodule

`default_nettype wire

// ==== dv/tbDecoderWithCc.sv ====
`default_nettype none

module tbDecoderWithCc;
    import isaPkg::*;
    import ctrlPkg::*;

    logic      clk = 1'b0;
    logic      rstN;
    instrT     instr;
    cycleT     cycle;
    aluStatusT aluStatus;
    logic      testFlag;
    logic      immFetchActive;
    romAddrT   immAddr;
    logic      needImm;
    aluCtrlT   aluCtrl;
    wrCtrlT    wrCtrl;
    memCtrlT   memCtrl;
    pcCtrlT    pcCtrl;
    logic      carryFlag;
    logic      zeroFlag;
    logic      ccOut;

    // Expected registered outputs and flags
    aluCtrlT   expAlu;
    wrCtrlT    expWr;
    memCtrlT   expMem;
    pcCtrlT    expPc;
    logic      expNeed;
    logic      mCarry;
    logic      mZero;
    logic      expCc;
    nibbleT    subCode;
    logic      atX2;
    logic      atX3;
    int        errorCount;
    int        checkCount;
    int unsigned seedDummy;

    decoderWithCc dut (
        .clk            (clk),
        .rstN           (rstN),
        .instr          (instr),
        .cycle          (cycle),
        .aluStatus      (aluStatus),
        .testFlag       (testFlag),
        .immFetchActive (immFetchActive),
        .immAddr        (immAddr),
        .needImm        (needImm),
        .aluCtrl        (aluCtrl),
        .wrCtrl         (wrCtrl),
        .memCtrl        (memCtrl),
        .pcCtrl         (pcCtrl),
        .carryFlag      (carryFlag),
        .zeroFlag       (zeroFlag),
        .ccOut          (ccOut)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // Reference model, follows the inputs held at each rising edge
    // ======================================================================
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            expAlu  = '{1'b0, 4'h0, 4'h0, SEL_NONE};
            expWr   = '0;
            expMem  = '0;
            expPc   = '0;
            expNeed = 1'b0;
            mCarry  = 1'b0;
            mZero   = 1'b0;
        end else begin
            subCode      = instr.opa.code;
            atX2         = (cycle == CYC_X2);
            atX3         = (cycle == CYC_X3);
            expAlu       = '{1'b0, 4'h0, 4'h0, SEL_NONE};
            expWr        = '0;
            expMem       = '0;
            expPc        = '0;
            expNeed      = 1'b0;
            expWr.tempWe = (cycle == CYC_X1);      // Every opcode
            case (instr.opr)
                INC, ADD, SUB, LD: begin
                    expAlu = '{1'b1, instr.opr, 4'h0, SEL_REG};
                    if (atX3) begin
                        expWr.regWe = (instr.opr == INC);
                        expWr.accWe = (instr.opr != INC);
                        if (instr.opr != LD) mCarry = aluStatus.carry;
                        mZero = aluStatus.zero;
                    end
                end
                XCH: begin
                    expWr.accWe     = atX3;
                    expWr.regWe     = atX3;
                    expWr.regSrcSel = atX3;
                end
                BBL, LDM: begin
                    expAlu         = '{1'b1, instr.opr, 4'h0, SEL_IMM};
                    expWr.accWe    = atX3;
                    expPc.stackPop = atX3 && (instr.opr == BBL);
                    if (atX3 && (instr.opr == LDM)) mZero = aluStatus.zero;
                end
                JUN, JMS: begin
                    if (atX3 && !immFetchActive) expNeed = 1'b1;   // First word
                    if (atX3 && immFetchActive) begin
                        expPc.pcLoad     = 1'b1;
                        expPc.pcLoadData = immAddr;
                        expPc.stackPush  = (instr.opr == JMS);
                    end
                end
                GRP_E: begin
                    case (subCode)
                        WRM, WR0, WR1, WR2, WR3: expMem.ramWe = atX3;
                        WMP, WRR:                expMem.ioWe  = atX3;
                        RDR: begin
                            expMem.ioRe = atX3;
                            expWr.accWe = atX3;
                        end
                        SBM, ADM, RDM, RD0, RD1, RD2, RD3: begin
                            expMem.ramRe = atX2;
                            expWr.accWe  = atX3;
                            if (atX2) begin
                                expAlu = '{1'b1, (subCode == SBM) ? SUB :
                                           (subCode == ADM) ? ADD : LD, 4'h0, SEL_RAM};
                            end
                            if (atX3 && (subCode == SBM || subCode == ADM)) begin
                                mCarry = aluStatus.carry;
                                mZero  = aluStatus.zero;
                            end
                        end
                        default: ;                  // WPM
                    endcase
                end
                GRP_F: begin
                    if (subCode <= KBP) expAlu = '{1'b1, GRP_F, subCode, SEL_NONE};
                    if (atX3) begin
                        case (subCode)
                            CLB, TCC, TCS: begin
                                expWr.accWe = 1'b1;
                                mCarry      = 1'b0;
                            end
                            CLC: mCarry = 1'b0;
                            STC: mCarry = 1'b1;
                            CMC: mCarry = ~mCarry;
                            IAC, DAC: begin
                                expWr.accWe = 1'b1;
                                mCarry      = aluStatus.carry;
                                mZero       = aluStatus.zero;
                            end
                            RAL, RAR, DAA: begin
                                expWr.accWe = 1'b1;
                                mCarry      = aluStatus.carry;
                            end
                            CMA, KBP: expWr.accWe = 1'b1;
                            default: ;              // Unused subcodes
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    task automatic reportValue(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        errorCount++;
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        expCc = ((instr.opa.cond.testLowEn & ~testFlag) | (instr.opa.cond.carryEn & mCarry)
                | (instr.opa.cond.zeroEn & mZero)) ^ instr.opa.cond.invert;
        checkCount += 8;
        assert (aluCtrl === expAlu) else reportValue("aluCtrl", 16'(aluCtrl), 16'(expAlu));
        assert (wrCtrl === expWr) else reportValue("wrCtrl", 16'(wrCtrl), 16'(expWr));
        assert (memCtrl === expMem) else reportValue("memCtrl", 16'(memCtrl), 16'(expMem));
        assert (pcCtrl === expPc) else reportValue("pcCtrl", 16'(pcCtrl), 16'(expPc));
        assert (needImm === expNeed) else reportValue("needImm", 16'(needImm), 16'(expNeed));
        assert (carryFlag === mCarry) else reportValue("carryFlag", 16'(carryFlag), 16'(mCarry));
        assert (zeroFlag === mZero) else reportValue("zeroFlag", 16'(zeroFlag), 16'(mZero));
        assert (ccOut === expCc) else reportValue("ccOut", 16'(ccOut), 16'(expCc));
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic driveStep(input instrT ins, input cycleT c, input logic ifa);
        @(posedge clk);
        #1;
        instr          = ins;
        cycle          = c;
        immFetchActive = ifa;
        aluStatus      = 2'($urandom_range(3, 0));   // Random flag history
        testFlag       = 1'($urandom_range(1, 0));
        immAddr        = romAddrT'($urandom);
    endtask

    task automatic runInstr(input nibbleT opr, input nibbleT opa, input logic ifa);
        instrT ins;
        int    c;
        ins.opr      = opr;
        ins.opa.code = opa;
        for (c = 0; c < 8; c++) begin
            driveStep(ins, cycleT'(c), ifa);
        end
    endtask

    task automatic longJump(input nibbleT opr);
        int   n;
        logic seen;
        runInstr(opr, nibbleT'($urandom_range(15, 0)), 1'b0);
        seen = 1'b0;
        for (n = 0; n < 4 && !seen; n++) begin
            @(posedge clk);
            #1;
            seen = needImm;
        end
        if (!seen) begin
            $display("needImm never rose after the first word of opcode %h", opr);
            errorCount++;
        end
        runInstr(opr, nibbleT'($urandom_range(15, 0)), 1'b1);  // Second word
    endtask

    initial begin
        #100000;
        $display("Run did not finish within its time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int i;
        int k;
        seedDummy      = $urandom(65774);
        rstN           = 1'b0;
        instr          = '0;
        cycle          = '0;
        aluStatus      = '0;
        testFlag       = 1'b0;
        immFetchActive = 1'b0;
        immAddr        = '0;
        errorCount     = 0;
        checkCount     = 0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;

        for (k = 0; k < 2; k++) begin
            for (i = 0; i < 16; i++) begin
                runInstr(nibbleT'(i), nibbleT'($urandom_range(15, 0)), 1'b0);
            end
        end
        for (k = 0; k < 2; k++) begin
            for (i = 0; i < 16; i++) begin
                runInstr(ADD, nibbleT'($urandom_range(15, 0)), 1'b0);  // Scramble flags
                runInstr(GRP_F, nibbleT'(i), 1'b0);
                runInstr(SUB, nibbleT'($urandom_range(15, 0)), 1'b0);
                runInstr(GRP_E, nibbleT'(i), 1'b0);
            end
        end
        for (i = 0; i < 20; i++) begin
            runInstr(JCN, nibbleT'($urandom_range(15, 0)), 1'b0);
        end
        longJump(JUN);
        longJump(JMS);
        runInstr(BBL, nibbleT'($urandom_range(15, 0)), 1'b0);
        for (i = 0; i < 200; i++) begin
            runInstr(nibbleT'($urandom_range(15, 0)), nibbleT'($urandom_range(15, 0)),
                     1'($urandom_range(1, 0)));
        end
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/flagUnit.sv
hw/jumpSequencer.sv
hw/eGroupDecoder.sv
hw/fGroupDecoder.sv
hw/instrDecoder.sv
hw/decoderWithCc.sv
dv/tbDecoderWithCc.sv
